// ==== Makefile ====
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
TOP       ?= exe_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
PASS_MSG  ?= No errors

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	$(SIM_BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hdl/exe_alu.sv ====
module exe_alu (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              instr_valid_i,
    input  exe_pkg::decoded_t dec_i,
    input  exe_pkg::word_t    rs_data_i,
    input  exe_pkg::word_t    rt_data_i,
    input  exe_pkg::word_t    pc_plus4_i,
    output exe_pkg::word_t    result_o
);
    import exe_pkg::*;

    word_t               ext_imm;
    word_t               op_b;
    logic [4:0]          sh_amt;
    logic                mul_signed;
    logic [2*DATA_W-1:0] mul_a;
    logic [2*DATA_W-1:0] mul_b;
    logic [2*DATA_W-1:0] product;
    word_t               hi_q;
    word_t               lo_q;

    assign ext_imm = dec_i.sign_ext ? {{(DATA_W-IMM_W){dec_i.imm[IMM_W-1]}}, dec_i.imm}
                                    : {{(DATA_W-IMM_W){1'b0}}, dec_i.imm};
    assign op_b    = dec_i.imm_sel ? ext_imm : rt_data_i;
    assign sh_amt  = dec_i.var_shift ? rs_data_i[4:0] : dec_i.shamt;

    ////////////////////
    // multiplier, one array for both signs

    assign mul_signed = (dec_i.alu_op == ALU_MULT);
    assign mul_a      = {{DATA_W{mul_signed & rs_data_i[DATA_W-1]}}, rs_data_i};
    assign mul_b      = {{DATA_W{mul_signed & rt_data_i[DATA_W-1]}}, rt_data_i};
    assign product    = mul_a * mul_b; // low half of the wide product

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (instr_valid_i && dec_i.alu_op inside {ALU_MULT, ALU_MULTU}) begin
            hi_q <= product[2*DATA_W-1:DATA_W];
            lo_q <= product[DATA_W-1:0];
        end
    end

    ////////////////////
    // result select

    always_comb begin
        case (dec_i.alu_op)
            ALU_SLL:  result_o = rt_data_i << sh_amt;
            ALU_SRL:  result_o = rt_data_i >> sh_amt;
            ALU_SRA:  result_o = $signed(rt_data_i) >>> sh_amt;
            ALU_ADD:  result_o = rs_data_i + op_b;
            ALU_SUB:  result_o = rs_data_i - op_b;
            ALU_AND:  result_o = rs_data_i & op_b;
            ALU_OR:   result_o = rs_data_i | op_b;
            ALU_XOR:  result_o = rs_data_i ^ op_b;
            ALU_NOR:  result_o = ~(rs_data_i | op_b);
            ALU_SLT:  result_o = {{(DATA_W-1){1'b0}}, $signed(rs_data_i) < $signed(op_b)};
            ALU_SLTU: result_o = {{(DATA_W-1){1'b0}}, rs_data_i < op_b};
            ALU_LUI:  result_o = {dec_i.imm, {(DATA_W-IMM_W){1'b0}}};
            ALU_HI:   result_o = hi_q;
            ALU_LO:   result_o = lo_q;
            ALU_PC4:  result_o = pc_plus4_i;
            default:  result_o = '0; // mult, multu, none
        endcase
    end

endmodule

// ==== hdl/exe_decode.sv ====
module exe_decode (
    input  exe_pkg::word_t    instr_i,
    output exe_pkg::decoded_t dec_o
);
    import exe_pkg::*;

    opcode_e  opcode;
    funct_e   funct;
    reg_idx_t rd;
    reg_idx_t rt;

    assign opcode = opcode_e'(instr_i[31:26]);
    assign funct  = funct_e'(instr_i[5:0]);
    assign rd     = instr_i[15:11];
    assign rt     = instr_i[20:16];

    always_comb begin
        dec_o        = '0;
        dec_o.alu_op = ALU_NONE;
        dec_o.rs     = instr_i[25:21]; // rs, rt, imm together form the jump target
        dec_o.rt     = rt;
        dec_o.shamt  = instr_i[10:6];
        dec_o.imm    = instr_i[15:0];
        dec_o.branch = BR_NONE;
        dec_o.jump   = JMP_NONE;

        case (opcode)
            OP_SPECIAL: begin
                dec_o.dest      = rd;
                dec_o.var_shift = (funct inside {FN_SLLV, FN_SRLV, FN_SRAV});
                case (funct)
                    FN_SLL, FN_SLLV:  dec_o.alu_op = ALU_SLL;
                    FN_SRL, FN_SRLV:  dec_o.alu_op = ALU_SRL;
                    FN_SRA, FN_SRAV:  dec_o.alu_op = ALU_SRA;
                    FN_ADD, FN_ADDU:  dec_o.alu_op = ALU_ADD; // no overflow trap
                    FN_SUB, FN_SUBU:  dec_o.alu_op = ALU_SUB;
                    FN_AND:           dec_o.alu_op = ALU_AND;
                    FN_OR:            dec_o.alu_op = ALU_OR;
                    FN_XOR:           dec_o.alu_op = ALU_XOR;
                    FN_NOR:           dec_o.alu_op = ALU_NOR;
                    FN_SLT:           dec_o.alu_op = ALU_SLT;
                    FN_SLTU:          dec_o.alu_op = ALU_SLTU;
                    FN_MFHI:          dec_o.alu_op = ALU_HI;
                    FN_MFLO:          dec_o.alu_op = ALU_LO;
                    FN_MULT, FN_MULTU: begin
                        dec_o.alu_op = (funct == FN_MULT) ? ALU_MULT : ALU_MULTU;
                        dec_o.dest   = '0;
                    end
                    FN_JR: begin
                        dec_o.jump = JMP_REG;
                        dec_o.dest = '0;
                    end
                    default: dec_o.dest = '0;
                endcase
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                dec_o.dest     = rt;
                dec_o.imm_sel  = 1'b1;
                dec_o.sign_ext = (opcode inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU});
                case (opcode)
                    OP_ADDI, OP_ADDIU: dec_o.alu_op = ALU_ADD;
                    OP_SLTI:           dec_o.alu_op = ALU_SLT;
                    OP_SLTIU:          dec_o.alu_op = ALU_SLTU;
                    OP_ANDI:           dec_o.alu_op = ALU_AND;
                    OP_ORI:            dec_o.alu_op = ALU_OR;
                    OP_XORI:           dec_o.alu_op = ALU_XOR;
                    default:           dec_o.alu_op = ALU_LUI;
                endcase
            end
            OP_LW: begin
                dec_o.dest     = rt; // any register may be loaded
                dec_o.load     = 1'b1;
                dec_o.sign_ext = 1'b1;
            end
            OP_SW: begin
                dec_o.store    = 1'b1;
                dec_o.sign_ext = 1'b1;
            end
            OP_BEQ:  dec_o.branch = BR_EQ;
            OP_BNE:  dec_o.branch = BR_NE;
            OP_J:    dec_o.jump = JMP_IMM;
            OP_JAL: begin
                dec_o.jump   = JMP_IMM;
                dec_o.dest   = 5'd31;
                dec_o.alu_op = ALU_PC4; // return address
            end
            default: ;
        endcase
    end

endmodule

// ==== hdl/exe_flow_ctrl.sv ====
module exe_flow_ctrl (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              instr_valid_i,
    input  exe_pkg::decoded_t dec_i,
    input  exe_pkg::word_t    rs_data_i,
    input  exe_pkg::word_t    rt_data_i,
    output exe_pkg::flow_t    flow_o
);
    import exe_pkg::*;

    logic taken;

    always_comb begin
        case (dec_i.branch)
            BR_EQ:   taken = (rs_data_i == rt_data_i);
            BR_NE:   taken = (rs_data_i != rt_data_i);
            default: taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            flow_o <= '0;
        end else begin
            flow_o <= '0; // valid for one cycle only
            if (instr_valid_i && taken) begin
                flow_o.b_valid <= 1'b1;
                flow_o.b_addr  <= dec_i.imm;
            end
            if (instr_valid_i && dec_i.jump != JMP_NONE) begin
                flow_o.j_valid <= 1'b1;
                flow_o.j_addr  <= (dec_i.jump == JMP_REG) ? rs_data_i[JADDR_W-1:0]
                                                          : {dec_i.rs, dec_i.rt, dec_i.imm};
            end
        end
    end

endmodule

// ==== hdl/exe_mem_wb.sv ====
module exe_mem_wb (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              instr_valid_i,
    input  exe_pkg::decoded_t dec_i,
    input  exe_pkg::word_t    rs_data_i,
    input  exe_pkg::word_t    rt_data_i,
    input  exe_pkg::word_t    alu_result_i,
    input  exe_pkg::word_t    data_load_i,
    output exe_pkg::mem_req_t mem_req_o,
    output exe_pkg::wb_t      wb_o
);
    import exe_pkg::*;

    word_t addr;
    wb_t   wb_q;

    assign addr = rs_data_i + {{(DATA_W-IMM_W){dec_i.imm[IMM_W-1]}}, dec_i.imm};

    ////////////////////
    // memory request

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mem_req_o <= '0;
        end else begin
            mem_req_o <= '0;
            if (instr_valid_i && (dec_i.load || dec_i.store)) begin
                mem_req_o.addr  <= addr;
                mem_req_o.wdata <= dec_i.store ? rt_data_i : '0;
                mem_req_o.we    <= dec_i.store; // one cycle per sw
            end
        end
    end

    ////////////////////
    // pending writeback

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wb_q <= '0;
        end else begin
            wb_q.we        <= instr_valid_i && (dec_i.dest != '0);
            wb_q.idx       <= dec_i.dest;
            wb_q.from_load <= dec_i.load;
            wb_q.data      <= alu_result_i;
        end
    end

    // load data arrives during the cycle after the lw
    always_comb begin
        wb_o = wb_q;
        if (wb_q.from_load) begin
            wb_o.data = data_load_i;
        end
    end

endmodule

// ==== hdl/exe_pkg.sv ====
package exe_pkg;

    localparam int DATA_W  = 32;
    localparam int REG_AW  = 5;
    localparam int IMM_W   = 16;
    localparam int JADDR_W = 26;

    typedef logic [REG_AW-1:0] reg_idx_t;
    typedef logic [DATA_W-1:0] word_t;

    ////////////////////
    // instruction encodings

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDI    = 6'h08,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL   = 6'h00,
        FN_SRL   = 6'h02,
        FN_SRA   = 6'h03,
        FN_SLLV  = 6'h04,
        FN_SRLV  = 6'h06,
        FN_SRAV  = 6'h07,
        FN_JR    = 6'h08,
        FN_MFHI  = 6'h10,
        FN_MFLO  = 6'h12,
        FN_MULT  = 6'h18,
        FN_MULTU = 6'h19,
        FN_ADD   = 6'h20,
        FN_ADDU  = 6'h21,
        FN_SUB   = 6'h22,
        FN_SUBU  = 6'h23,
        FN_AND   = 6'h24,
        FN_OR    = 6'h25,
        FN_XOR   = 6'h26,
        FN_NOR   = 6'h27,
        FN_SLT   = 6'h2a,
        FN_SLTU  = 6'h2b
    } funct_e;

    typedef enum logic [4:0] {
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_ADD, ALU_SUB, ALU_AND,
        ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU, ALU_LUI,
        ALU_HI, ALU_LO, ALU_PC4, ALU_MULT, ALU_MULTU, ALU_NONE
    } alu_op_e;

    typedef enum logic [1:0] {BR_NONE, BR_EQ, BR_NE} br_kind_e;
    typedef enum logic [1:0] {JMP_NONE, JMP_IMM, JMP_REG} jmp_kind_e;

    ////////////////////
    // stage records

    typedef struct packed {
        alu_op_e          alu_op;
        reg_idx_t         rs;
        reg_idx_t         rt;
        reg_idx_t         dest;       // 0 means no write
        logic             imm_sel;
        logic             var_shift;
        logic             sign_ext;
        logic [4:0]       shamt;
        logic [IMM_W-1:0] imm;
        logic             load;
        logic             store;
        br_kind_e         branch;
        jmp_kind_e        jump;
    } decoded_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  we;
    } mem_req_t;

    typedef struct packed {
        logic               j_valid;
        logic [JADDR_W-1:0] j_addr;
        logic               b_valid;
        logic [IMM_W-1:0]   b_addr;
    } flow_t;

    typedef struct packed {
        logic     we;
        reg_idx_t idx;
        logic     from_load;
        word_t    data;
    } wb_t;

endpackage

// ==== hdl/exe_regfile.sv ====
module exe_regfile #(
    parameter exe_pkg::word_t SP_INIT = 32'h0000_3fff
) (
    input  logic              clk_i,
    input  logic              reset_i,
    input  exe_pkg::reg_idx_t rs_idx_i,
    input  exe_pkg::reg_idx_t rt_idx_i,
    input  exe_pkg::wb_t      wb_i,
    output exe_pkg::word_t    rs_data_o,
    output exe_pkg::word_t    rt_data_o
);
    import exe_pkg::*;

    localparam reg_idx_t SP_IDX = 5'd29;

    word_t regs [2**REG_AW];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < 2**REG_AW; i++) begin
                regs[i] <= '0;
            end
            regs[SP_IDX] <= SP_INIT; // stack pointer
        end else if (wb_i.we && wb_i.idx != '0) begin
            regs[wb_i.idx] <= wb_i.data;
        end
    end

    // pending writeback bypasses the array
    function automatic word_t read_port(reg_idx_t idx);
        word_t val;
        if (idx == '0) begin
            val = '0;
        end else if (wb_i.we && wb_i.idx == idx) begin
            val = wb_i.data;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_comb begin
        rs_data_o = read_port(rs_idx_i);
        rt_data_o = read_port(rt_idx_i);
    end

endmodule

// ==== hdl/exe_stage.sv ====
module exe_stage #(
    parameter exe_pkg::word_t SP_INIT = 32'h0000_3fff
) (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              instr_valid_i,
    input  exe_pkg::word_t    instr_i,
    input  exe_pkg::word_t    pc_plus4_i,
    input  exe_pkg::word_t    data_load_i,
    output exe_pkg::mem_req_t mem_req_o,
    output exe_pkg::flow_t    flow_o
);
    import exe_pkg::*;

    decoded_t dec;
    word_t    rs_data;
    word_t    rt_data;
    word_t    alu_result;
    wb_t      wb;

    exe_decode u_decode (
        .instr_i (instr_i),
        .dec_o   (dec)
    );

    exe_regfile #(
        .SP_INIT (SP_INIT)
    ) u_regfile (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .rs_idx_i  (dec.rs),
        .rt_idx_i  (dec.rt),
        .wb_i      (wb),
        .rs_data_o (rs_data),
        .rt_data_o (rt_data)
    );

    exe_alu u_alu (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .instr_valid_i (instr_valid_i),
        .dec_i         (dec),
        .rs_data_i     (rs_data),
        .rt_data_i     (rt_data),
        .pc_plus4_i    (pc_plus4_i),
        .result_o      (alu_result)
    );

    exe_flow_ctrl u_flow_ctrl (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .instr_valid_i (instr_valid_i),
        .dec_i         (dec),
        .rs_data_i     (rs_data),
        .rt_data_i     (rt_data),
        .flow_o        (flow_o)
    );

    exe_mem_wb u_mem_wb (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .instr_valid_i (instr_valid_i),
        .dec_i         (dec),
        .rs_data_i     (rs_data),
        .rt_data_i     (rt_data),
        .alu_result_i  (alu_result),
        .data_load_i   (data_load_i),
        .mem_req_o     (mem_req_o),
        .wb_o          (wb)
    );

endmodule

// ==== sources.f ====
hdl/exe_pkg.sv
hdl/exe_decode.sv
hdl/exe_regfile.sv
hdl/exe_alu.sv
hdl/exe_flow_ctrl.sv
hdl/exe_mem_wb.sv
hdl/exe_stage.sv
test/exe_checker.sv
test/exe_tb.sv

// ==== test/exe_checker.sv ====
module exe_checker (
    input  logic              clk_i,
    input  logic              check_i,
    input  int                idx_i,
    input  exe_pkg::word_t    instr_i,
    input  exe_pkg::mem_req_t exp_mem_i,
    input  exe_pkg::flow_t    exp_flow_i,
    input  logic [3:0]        chk_i,      // flow, we, wdata, addr
    input  exe_pkg::mem_req_t mem_req_i,
    input  exe_pkg::flow_t    flow_i,
    output int                checked_o,
    output int                errors_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import exe_pkg::*;

    logic       p_valid;
    int         p_idx;
    word_t      p_instr;
    mem_req_t   p_mem;
    flow_t      p_flow;
    logic [3:0] p_chk;

    initial begin
        p_valid   = 1'b0;
        checked_o = 0;
        errors_o  = 0;
    end

    // entry issued this cycle, outputs due in the next one
    always @(posedge clk_i) begin
        p_valid <= check_i;
        p_idx   <= idx_i;
        p_instr <= instr_i;
        p_mem   <= exp_mem_i;
        p_flow  <= exp_flow_i;
        p_chk   <= chk_i;
    end

    function automatic int field_bad(string name, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            $display("Fail %s expected 0x%h actual 0x%h (entry %0d)", name, exp, act, p_idx);
            return 1;
        end
        return 0;
    endfunction

    task automatic check_entry();
        int bad;
        bad = 0;
        if (p_chk[0]) begin
            bad += field_bad("mem_req_o.addr", p_mem.addr, mem_req_i.addr);
        end
        if (p_chk[1]) begin
            bad += field_bad("mem_req_o.wdata", p_mem.wdata, mem_req_i.wdata);
        end
        if (p_chk[2]) begin
            bad += field_bad("mem_req_o.we", 32'(p_mem.we), 32'(mem_req_i.we));
        end
        if (p_chk[3]) begin
            bad += field_bad("flow_o.j_valid", 32'(p_flow.j_valid), 32'(flow_i.j_valid));
            bad += field_bad("flow_o.j_addr", 32'(p_flow.j_addr), 32'(flow_i.j_addr));
            bad += field_bad("flow_o.b_valid", 32'(p_flow.b_valid), 32'(flow_i.b_valid));
            bad += field_bad("flow_o.b_addr", 32'(p_flow.b_addr), 32'(flow_i.b_addr));
        end
        if (bad == 0) begin
            $display("entry %0d  instr %h  ok", p_idx, p_instr);
        end else begin
            $display("entry %0d  instr %h  %0d mismatches", p_idx, p_instr, bad);
        end
        errors_o  = errors_o + bad;
        checked_o = checked_o + 1;
    endtask

    always @(negedge clk_i) begin
        if (p_valid) begin
            check_entry();
        end
    end

endmodule

// ==== test/exe_tb.sv ====
module exe_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import exe_pkg::*;

    localparam word_t      SP_INIT   = 32'h0000_3fff;
    localparam logic [3:0] CHK_ADDR  = 4'b0001;
    localparam logic [3:0] CHK_WDATA = 4'b0010;
    localparam logic [3:0] CHK_WE    = 4'b0100;
    localparam logic [3:0] CHK_FLOW  = 4'b1000;
    localparam logic [3:0] CHK_ALL   = CHK_ADDR | CHK_WDATA | CHK_WE | CHK_FLOW;
    localparam logic [3:0] CHK_CTRL  = CHK_WE | CHK_FLOW;

    localparam funct_e R_FNS [16] = '{FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR,
        FN_XOR, FN_NOR, FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV};

    typedef struct packed {
        logic     valid;
        word_t    instr;
        word_t    pc4;
        mem_req_t exp_mem;
        flow_t    exp_flow;
        logic [3:0] chk;
    } entry_t;

    logic       clk;
    logic       reset;
    logic       instr_valid;
    word_t      instr;
    word_t      pc_plus4;
    word_t      data_load;
    mem_req_t   mem_req;
    flow_t      flow;

    logic       check;
    int         cur_idx;
    word_t      cur_instr;
    mem_req_t   exp_mem;
    flow_t      exp_flow;
    logic [3:0] chk;
    int         checked;
    int         errors;

    word_t      dmem [64];
    word_t      ref_mem [64];   // memory as the program sees it
    word_t      rf [32];
    word_t      hi;
    word_t      lo;
    word_t      pc_next;
    entry_t     stim_q [$];
    int         cycles = 0;
    int         cycle_limit = 0;

    exe_stage #(
        .SP_INIT (SP_INIT)
    ) dut (
        .clk_i         (clk),
        .reset_i       (reset),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .pc_plus4_i    (pc_plus4),
        .data_load_i   (data_load),
        .mem_req_o     (mem_req),
        .flow_o        (flow)
    );

    exe_checker u_checker (
        .clk_i      (clk),
        .check_i    (check),
        .idx_i      (cur_idx),
        .instr_i    (cur_instr),
        .exp_mem_i  (exp_mem),
        .exp_flow_i (exp_flow),
        .chk_i      (chk),
        .mem_req_i  (mem_req),
        .flow_i     (flow),
        .checked_o  (checked),
        .errors_o   (errors)
    );

    always #10 clk = ~clk;

    ////////////////////
    // data memory

    assign data_load = dmem[mem_req.addr[7:2]];

    always @(posedge clk) begin
        if (mem_req.we) begin
            dmem[mem_req.addr[7:2]] <= mem_req.wdata;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("timeout: the table did not finish within %0d cycles", cycle_limit);
            $display("Errors found");
            $finish;
        end
    end

    ////////////////////
    // program builder

    function automatic word_t fill_word(logic [5:0] idx);
        return {10'h2b5, idx, 10'h133, idx};
    endfunction

    function automatic word_t sext(logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    function automatic logic [15:0] rand_imm();
        return 16'($urandom);
    endfunction

    function automatic logic [15:0] word_offset();
        return {8'h00, 6'($urandom), 2'b00}; // from r0, anywhere in memory
    endfunction

    function automatic logic [15:0] mem_offset();
        logic [7:0] b;
        b = {6'($urandom), 2'b00};
        return {{8{b[7]}}, b}; // -128..124 around r8
    endfunction

    task automatic push_entry(logic valid, word_t ins, mem_req_t m, flow_t f, logic [3:0] c);
        entry_t e;
        e.valid    = valid;
        e.instr    = ins;
        e.pc4      = pc_next;
        e.exp_mem  = m;
        e.exp_flow = f;
        e.chk      = c;
        stim_q.push_back(e);
        pc_next = pc_next + 32'd4;
    endtask

    task automatic set_reg(reg_idx_t idx, word_t val);
        if (idx != 5'd0) begin
            rf[idx] = val;
        end
    endtask

    task automatic imm_op(opcode_e op, reg_idx_t rt, reg_idx_t rs, logic [15:0] imm);
        word_t a;
        word_t r;
        a = rf[rs];
        case (op)
            OP_ADDI, OP_ADDIU: r = a + sext(imm);
            OP_SLTI:           r = {31'h0, $signed(a) < $signed(sext(imm))};
            OP_SLTIU:          r = {31'h0, a < sext(imm)};
            OP_ANDI:           r = a & {16'h0, imm};
            OP_ORI:            r = a | {16'h0, imm};
            OP_XORI:           r = a ^ {16'h0, imm};
            default:           r = {imm, 16'h0}; // lui
        endcase
        set_reg(rt, r);
        push_entry(1'b1, {op, rs, rt, imm}, '0, '0, CHK_CTRL);
    endtask

    task automatic reg_op(funct_e fn, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt, logic [4:0] sh);
        word_t       a;
        word_t       b;
        word_t       r;
        logic [4:0]  s;
        logic [63:0] p;
        a = rf[rs];
        b = rf[rt];
        s = (fn inside {FN_SLLV, FN_SRLV, FN_SRAV}) ? a[4:0] : sh;
        r = '0;
        case (fn)
            FN_ADD, FN_ADDU:  r = a + b;
            FN_SUB, FN_SUBU:  r = a - b;
            FN_AND:           r = a & b;
            FN_OR:            r = a | b;
            FN_XOR:           r = a ^ b;
            FN_NOR:           r = ~(a | b);
            FN_SLT:           r = {31'h0, $signed(a) < $signed(b)};
            FN_SLTU:          r = {31'h0, a < b};
            FN_SLL, FN_SLLV:  r = b << s;
            FN_SRL, FN_SRLV:  r = b >> s;
            FN_SRA, FN_SRAV:  r = (b >> s) | (b[31] ? ~(32'hffff_ffff >> s) : 32'h0);
            FN_MFHI:          r = hi;
            FN_MFLO:          r = lo;
            FN_MULT, FN_MULTU: begin
                if (fn == FN_MULT) begin
                    p = longint'($signed(a)) * longint'($signed(b));
                end else begin
                    p = {32'h0, a} * {32'h0, b};
                end
                hi = p[63:32];
                lo = p[31:0];
            end
            default: r = '0;
        endcase
        set_reg(rd, r);
        push_entry(1'b1, {OP_SPECIAL, rs, rt, rd, sh, fn}, '0, '0, CHK_CTRL);
    endtask

    task automatic store_word(reg_idx_t rt, reg_idx_t base, logic [15:0] imm);
        mem_req_t m;
        m.addr  = rf[base] + sext(imm);
        m.wdata = rf[rt];
        m.we    = 1'b1;
        ref_mem[m.addr[7:2]] = rf[rt];
        push_entry(1'b1, {OP_SW, base, rt, imm}, m, '0, CHK_ALL);
    endtask

    task automatic load_word(reg_idx_t rt, reg_idx_t base, logic [15:0] imm);
        mem_req_t m;
        m.addr  = rf[base] + sext(imm);
        m.wdata = '0;
        m.we    = 1'b0;
        set_reg(rt, ref_mem[m.addr[7:2]]);
        push_entry(1'b1, {OP_LW, base, rt, imm}, m, '0, CHK_ADDR | CHK_WE | CHK_FLOW);
    endtask

    task automatic branch_on(opcode_e op, reg_idx_t rs, reg_idx_t rt, logic [15:0] imm);
        flow_t f;
        f = '0;
        if ((op == OP_BEQ) ? (rf[rs] == rf[rt]) : (rf[rs] != rf[rt])) begin
            f.b_valid = 1'b1;
            f.b_addr  = imm;
        end
        push_entry(1'b1, {op, rs, rt, imm}, '0, f, CHK_CTRL);
    endtask

    task automatic jump_to(opcode_e op, logic [25:0] target);
        flow_t f;
        f = '0;
        f.j_valid = 1'b1;
        f.j_addr  = target;
        if (op == OP_JAL) begin
            set_reg(5'd31, pc_next); // return address is this entry's pc_plus4
        end
        push_entry(1'b1, {op, target}, '0, f, CHK_CTRL);
    endtask

    task automatic jump_reg(reg_idx_t rs);
        flow_t f;
        f = '0;
        f.j_valid = 1'b1;
        f.j_addr  = rf[rs][25:0];
        push_entry(1'b1, {OP_SPECIAL, rs, 15'h0, FN_JR}, '0, f, CHK_CTRL);
    endtask

    task automatic idle_cycle();
        push_entry(1'b0, {OP_JAL, 26'($urandom)}, '0, '0, CHK_CTRL); // must have no effect
    endtask

    task automatic build_program();
        logic [15:0] off;
        pc_next = 32'h0040_0000;
        hi      = '0;
        lo      = '0;
        foreach (rf[i]) begin
            rf[i] = '0;
        end
        rf[29] = SP_INIT;
        foreach (ref_mem[i]) begin
            ref_mem[i] = fill_word(6'(i));
        end

        idle_cycle();
        store_word(5'd29, 5'd0, 16'h0000);
        imm_op(OP_ADDI, 5'd1, 5'd0, rand_imm());
        imm_op(OP_ORI, 5'd2, 5'd0, rand_imm());
        imm_op(OP_LUI, 5'd3, 5'd0, rand_imm());
        imm_op(OP_ORI, 5'd3, 5'd3, rand_imm()); // forwarded from lui
        imm_op(OP_ADDIU, 5'd4, 5'd1, rand_imm());
        imm_op(OP_SLTI, 5'd5, 5'd1, rand_imm());
        imm_op(OP_SLTIU, 5'd6, 5'd2, rand_imm());
        imm_op(OP_ANDI, 5'd7, 5'd3, rand_imm());
        imm_op(OP_XORI, 5'd9, 5'd3, rand_imm());
        for (int i = 4; i <= 9; i++) begin
            store_word(5'(i), 5'd0, word_offset());
        end
        foreach (R_FNS[i]) begin
            reg_op(R_FNS[i], 5'd10, 5'd1, 5'd3, 5'($urandom));
            store_word(5'd10, 5'd0, word_offset());
        end

        // multiply, then read both halves back
        reg_op(FN_MULT, 5'd0, 5'd1, 5'd3, 5'd0);
        reg_op(FN_MFHI, 5'd12, 5'd0, 5'd0, 5'd0);
        store_word(5'd12, 5'd0, word_offset());
        reg_op(FN_MFLO, 5'd13, 5'd0, 5'd0, 5'd0);
        store_word(5'd13, 5'd0, word_offset());
        reg_op(FN_MULTU, 5'd0, 5'd1, 5'd3, 5'd0);
        reg_op(FN_MFHI, 5'd12, 5'd0, 5'd0, 5'd0);
        store_word(5'd12, 5'd0, word_offset());
        reg_op(FN_MFLO, 5'd13, 5'd0, 5'd0, 5'd0);
        store_word(5'd13, 5'd0, word_offset());

        imm_op(OP_ORI, 5'd8, 5'd0, 16'h0080);
        off = mem_offset();
        store_word(5'd2, 5'd8, off);
        load_word(5'd14, 5'd8, off);
        store_word(5'd14, 5'd0, word_offset()); // load data forwarded
        load_word(5'd15, 5'd8, mem_offset());
        store_word(5'd15, 5'd0, word_offset());

        branch_on(OP_BEQ, 5'd1, 5'd1, rand_imm());
        branch_on(OP_BEQ, 5'd1, 5'd2, rand_imm());
        branch_on(OP_BNE, 5'd1, 5'd2, rand_imm());
        branch_on(OP_BNE, 5'd3, 5'd3, rand_imm());

        jump_to(OP_J, 26'($urandom));
        jump_to(OP_JAL, 26'($urandom));
        store_word(5'd31, 5'd0, word_offset());
        idle_cycle();
        store_word(5'd31, 5'd0, word_offset()); // idle jal leaves r31 alone
        jump_reg(5'd3);
        idle_cycle();
        idle_cycle();
    endtask

    ////////////////////
    // run

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        pc_plus4    = '0;
        check       = 1'b0;
        cur_idx     = 0;
        cur_instr   = '0;
        exp_mem     = '0;
        exp_flow    = '0;
        chk         = '0;
        void'($urandom(32'h854a));
        foreach (dmem[i]) begin
            dmem[i] = fill_word(6'(i));
        end
        build_program();
        cycle_limit = 16 + stim_q.size() + 20;

        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        foreach (stim_q[i]) begin
            @(posedge clk);
            #1;
            instr_valid = stim_q[i].valid;
            instr       = stim_q[i].instr;
            pc_plus4    = stim_q[i].pc4;
            check       = 1'b1;
            cur_idx     = i;
            cur_instr   = stim_q[i].instr;
            exp_mem     = stim_q[i].exp_mem;
            exp_flow    = stim_q[i].exp_flow;
            chk         = stim_q[i].chk;
        end
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        check       = 1'b0;

        while (checked < stim_q.size()) begin
            @(posedge clk);
        end
        $display("%0d entries checked, %0d mismatches", checked, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
